// ==== src/tluh_pkg.sv ====
`default_nettype none

package tluh_pkg;

  ////////////////////////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////////////////////////
  localparam int TL_DW     = 32; // data bits per beat
  localparam int TL_DBW    = TL_DW / 8; // byte lanes
  localparam int TL_AW     = 32;
  localparam int TL_SZW    = 3;  // log2 of transfer bytes
  localparam int TL_IW     = 4;  // source id
  localparam int TL_BEATSW = 3;  // beat counter, bursts up to 4 beats

  ////////////////////////////////////////////////////////////
  // channel opcodes
  ////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    PutFullData    = 3'd0,
    PutPartialData = 3'd1,
    ArithmeticData = 3'd2,
    LogicalData    = 3'd3,
    Get            = 3'd4,
    Intent         = 3'd5  // prefetch hint
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1,
    HintAck       = 3'd2
  } tl_d_op_e;

  // a_param encodings of the atomics
  typedef enum logic [2:0] {
    MIN  = 3'd0,
    MAX  = 3'd1,
    MINU = 3'd2,
    MAXU = 3'd3,
    ADD  = 3'd4
  } arith_fn_e;

  typedef enum logic [2:0] {
    XOR  = 3'd0,
    OR   = 3'd1,
    AND  = 3'd2,
    SWAP = 3'd3  // plain exchange
  } logic_fn_e;

endpackage

`default_nettype wire

// ==== src/reg_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// word access path between adapter and register array
interface reg_bus_if #(
  parameter int RegAw = 6
) ();

  logic                          re;    // read strobe
  logic                          we;    // write strobe, acts at clock edge
  logic [RegAw-1:0]              addr;  // always word aligned
  logic [tluh_pkg::TL_DW-1:0]    wdata;
  logic [tluh_pkg::TL_DBW-1:0]   be;    // byte lanes to write
  logic [tluh_pkg::TL_DW-1:0]    rdata; // comb from addr
  logic                          error; // index beyond implemented words

  // adapter side
  modport host (
    output re, we, addr, wdata, be,
    input  rdata, error
  );

  // register array side
  modport device (
    input  re, we, addr, wdata, be,
    output rdata, error
  );

endinterface

`default_nettype wire

// ==== src/tluh_atomic_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tluh_atomic_alu (
  input  wire logic [tluh_pkg::TL_DW-1:0] op1_i,   // bus data
  input  wire logic [tluh_pkg::TL_DW-1:0] op2_i,   // old register word
  input  wire logic                       arith_i, // 1 arithmetic, 0 logical
  input  wire logic [2:0]                 fn_i,
  output logic      [tluh_pkg::TL_DW-1:0] result_o
);

  logic lt_s; // op1 < op2 as signed
  logic lt_u; // op1 < op2 as unsigned

  assign lt_s = $signed(op1_i) < $signed(op2_i);
  assign lt_u = op1_i < op2_i;

  ////////////////////////////////////////////////////////////
  // function select
  ////////////////////////////////////////////////////////////
  always_comb begin
    result_o = op1_i; // unknown codes fall back to swap
    if (arith_i) begin
      case (tluh_pkg::arith_fn_e'(fn_i))
        tluh_pkg::MIN:  result_o = lt_s ? op1_i : op2_i;
        tluh_pkg::MAX:  result_o = lt_s ? op2_i : op1_i;
        tluh_pkg::MINU: result_o = lt_u ? op1_i : op2_i;
        tluh_pkg::MAXU: result_o = lt_u ? op2_i : op1_i;
        tluh_pkg::ADD:  result_o = op1_i + op2_i; // wraps mod 2^32
        default:        result_o = op1_i;
      endcase
    end else begin
      case (tluh_pkg::logic_fn_e'(fn_i))
        tluh_pkg::XOR:  result_o = op1_i ^ op2_i;
        tluh_pkg::OR:   result_o = op1_i | op2_i;
        tluh_pkg::AND:  result_o = op1_i & op2_i;
        tluh_pkg::SWAP: result_o = op1_i;
        default:        result_o = op1_i;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/tluh_adapter_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module tluh_adapter_reg #(
  parameter int RegAw = 6
) (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  // channel A
  input  wire logic                          a_valid_i,
  input  wire tluh_pkg::tl_a_op_e            a_opcode_i,
  input  wire logic [2:0]                    a_param_i,
  input  wire logic [tluh_pkg::TL_SZW-1:0]   a_size_i,
  input  wire logic [tluh_pkg::TL_IW-1:0]    a_source_i,
  input  wire logic [tluh_pkg::TL_AW-1:0]    a_address_i,
  input  wire logic [tluh_pkg::TL_DBW-1:0]   a_mask_i,
  input  wire logic [tluh_pkg::TL_DW-1:0]    a_data_i,
  input  wire logic                          d_ready_i,
  output logic                               a_ready_o,
  // channel D
  output logic                               d_valid_o,
  output tluh_pkg::tl_d_op_e                 d_opcode_o,
  output logic      [tluh_pkg::TL_SZW-1:0]   d_size_o,
  output logic      [tluh_pkg::TL_IW-1:0]    d_source_o,
  output logic      [tluh_pkg::TL_DW-1:0]    d_data_o,
  output logic                               d_error_o,
  // prefetch hint
  output logic                               prefetch_o,
  output logic      [1:0]                    prefetch_param_o,
  output logic      [tluh_pkg::TL_AW-1:0]    prefetch_addr_o,
  // atomic ALU
  output logic      [tluh_pkg::TL_DW-1:0]    alu_op1_o,
  output logic      [tluh_pkg::TL_DW-1:0]    alu_op2_o,
  output logic                               alu_arith_o,
  output logic      [2:0]                    alu_fn_o,
  input  wire logic [tluh_pkg::TL_DW-1:0]    alu_result_i,
  reg_bus_if.host                            reg_bus
);

  localparam logic [RegAw-1:0] Step = RegAw'(tluh_pkg::TL_DBW); // one word

  typedef enum logic [2:0] {
    IDLE,
    GET_BEAT,     // D holds a read beat
    PUT_BEAT,     // waiting on further put beats
    ATOMIC_WRITE, // result goes back to the array
    RESPOND       // single ack on D
  } state_e;

  state_e state_q;

  logic a_ack, d_ack;
  logic a_new; // first beat of a request
  logic is_get, is_put, is_atomic, is_intent;

  logic [RegAw-1:0] a_word;  // word aligned request address
  logic [RegAw-1:0] addr_q;  // address of the next array access

  logic [tluh_pkg::TL_IW-1:0]     src_q;
  logic [tluh_pkg::TL_SZW-1:0]    size_q;
  tluh_pkg::tl_d_op_e             rspop_q;
  logic                           err_q;
  logic [tluh_pkg::TL_BEATSW-1:0] beats_q; // beats still to go
  logic [tluh_pkg::TL_DW-1:0]     rdata_q;

  // latched atomic operands
  logic [tluh_pkg::TL_DW-1:0] op1_q;
  logic [2:0]                 fn_q;
  logic                       arith_q;

  // beats minus one for a given size
  function automatic logic [tluh_pkg::TL_BEATSW-1:0] beats_m1(
    input logic [tluh_pkg::TL_SZW-1:0] size
  );
    logic [tluh_pkg::TL_BEATSW-1:0] n;
    n = '0;
    if (size > 3'd2) begin
      n = 1'b1;
      n = (n << (size - 3'd2)) - 1'b1;
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // handshakes and decode
  ////////////////////////////////////////////////////////////
  assign a_ready_o = (state_q == IDLE) || (state_q == PUT_BEAT);
  assign d_valid_o = (state_q == GET_BEAT) || (state_q == RESPOND);
  assign a_ack     = a_valid_i & a_ready_o;
  assign d_ack     = d_valid_o & d_ready_i;
  assign a_new     = a_ack & (state_q == IDLE);

  assign is_get    = a_opcode_i == tluh_pkg::Get;
  assign is_put    = (a_opcode_i == tluh_pkg::PutFullData) ||
                     (a_opcode_i == tluh_pkg::PutPartialData);
  assign is_atomic = (a_opcode_i == tluh_pkg::ArithmeticData) ||
                     (a_opcode_i == tluh_pkg::LogicalData);
  assign is_intent = a_opcode_i == tluh_pkg::Intent;

  assign a_word = {a_address_i[RegAw-1:2], 2'b00};

  ////////////////////////////////////////////////////////////
  // register bus
  ////////////////////////////////////////////////////////////
  assign reg_bus.addr  = (state_q == IDLE) ? a_word : addr_q;
  assign reg_bus.re    = (a_new & (is_get | is_atomic)) |
                         ((state_q == GET_BEAT) & d_ack & (beats_q != '0)); // next burst word
  assign reg_bus.we    = (a_ack & (is_put | (state_q == PUT_BEAT))) |
                         (state_q == ATOMIC_WRITE);
  assign reg_bus.wdata = (state_q == ATOMIC_WRITE) ? alu_result_i : a_data_i;
  assign reg_bus.be    = (state_q == ATOMIC_WRITE) ? '1 : a_mask_i; // atomics write whole word

  // hint goes out in the handshake cycle
  assign prefetch_o       = a_new & is_intent;
  assign prefetch_param_o = a_param_i[1:0];
  assign prefetch_addr_o  = a_address_i;

  ////////////////////////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      src_q   <= '0;
      size_q  <= '0;
      rspop_q <= tluh_pkg::AccessAck;
      err_q   <= 1'b0;
      beats_q <= '0;
      addr_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (a_ack) begin
            src_q   <= a_source_i;
            size_q  <= a_size_i;
            beats_q <= beats_m1(a_size_i);
            err_q   <= reg_bus.error;
            addr_q  <= a_word + Step; // wraps inside RegAw
            case (a_opcode_i)
              tluh_pkg::Get: begin
                rspop_q <= tluh_pkg::AccessAckData;
                state_q <= GET_BEAT;
              end
              tluh_pkg::PutFullData, tluh_pkg::PutPartialData: begin
                rspop_q <= tluh_pkg::AccessAck;
                state_q <= (beats_m1(a_size_i) == '0) ? RESPOND : PUT_BEAT;
              end
              tluh_pkg::ArithmeticData, tluh_pkg::LogicalData: begin
                rspop_q <= tluh_pkg::AccessAckData;
                addr_q  <= a_word; // same word gets the result
                state_q <= ATOMIC_WRITE;
              end
              tluh_pkg::Intent: begin
                rspop_q <= tluh_pkg::HintAck;
                err_q   <= 1'b0; // hints never fail
                state_q <= RESPOND;
              end
              default: begin
                rspop_q <= tluh_pkg::AccessAck;
                err_q   <= 1'b1; // unknown opcode
                state_q <= RESPOND;
              end
            endcase
          end
        end
        GET_BEAT: begin
          if (d_ack) begin
            if (beats_q == '0) begin
              state_q <= IDLE;
            end else begin
              beats_q <= beats_q - 1'b1;
              err_q   <= reg_bus.error; // per beat
              addr_q  <= addr_q + Step;
            end
          end
        end
        PUT_BEAT: begin
          if (a_ack) begin
            err_q   <= err_q | reg_bus.error; // sticky over the burst
            addr_q  <= addr_q + Step;
            beats_q <= beats_q - 1'b1;
            if (beats_q == 1) state_q <= RESPOND;
          end
        end
        ATOMIC_WRITE: state_q <= RESPOND;
        RESPOND: begin
          if (d_ack) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // data path, loaded on strobes only
  always_ff @(posedge clk_i) begin
    if (reg_bus.re) rdata_q <= reg_bus.rdata; // old word for atomics too
    if (a_new) begin
      op1_q   <= a_data_i;
      fn_q    <= a_param_i;
      arith_q <= a_opcode_i == tluh_pkg::ArithmeticData;
    end
  end

  assign d_opcode_o = rspop_q;
  assign d_size_o   = size_q;
  assign d_source_o = src_q;
  assign d_data_o   = rdata_q;
  assign d_error_o  = err_q;

  assign alu_op1_o   = op1_q;
  assign alu_op2_o   = rdata_q;
  assign alu_arith_o = arith_q;
  assign alu_fn_o    = fn_q;

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file #(
  parameter int RegAw   = 6,
  parameter int NumRegs = 12
) (
  input wire logic  clk_i,
  input wire logic  rst_ni,
  reg_bus_if.device reg_bus
);

  localparam int IdxW = RegAw - 2; // word index bits

  logic [tluh_pkg::TL_DW-1:0] regs [NumRegs];
  logic [IdxW-1:0]            idx;

  assign idx           = reg_bus.addr[RegAw-1:2];
  assign reg_bus.error = 32'(idx) >= NumRegs; // hole above implemented words
  // holes and idle cycles read zero
  assign reg_bus.rdata = (reg_bus.re && !reg_bus.error) ? regs[idx] : '0;

  ////////////////////////////////////////////////////////////
  // byte masked write
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_bus.we && !reg_bus.error) begin
      for (int b = 0; b < tluh_pkg::TL_DBW; b++) begin
        if (reg_bus.be[b]) regs[idx][8*b +: 8] <= reg_bus.wdata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/tluh_reg_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tluh_reg_top #(
  parameter int RegAw   = 6,
  parameter int NumRegs = 12
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire logic                        a_valid_i,
  input  wire tluh_pkg::tl_a_op_e          a_opcode_i,
  input  wire logic [2:0]                  a_param_i,
  input  wire logic [tluh_pkg::TL_SZW-1:0] a_size_i,
  input  wire logic [tluh_pkg::TL_IW-1:0]  a_source_i,
  input  wire logic [tluh_pkg::TL_AW-1:0]  a_address_i,
  input  wire logic [tluh_pkg::TL_DBW-1:0] a_mask_i,
  input  wire logic [tluh_pkg::TL_DW-1:0]  a_data_i,
  input  wire logic                        d_ready_i,
  output logic                             a_ready_o,
  output logic                             d_valid_o,
  output tluh_pkg::tl_d_op_e               d_opcode_o,
  output logic      [tluh_pkg::TL_SZW-1:0] d_size_o,
  output logic      [tluh_pkg::TL_IW-1:0]  d_source_o,
  output logic      [tluh_pkg::TL_DW-1:0]  d_data_o,
  output logic                             d_error_o,
  output logic                             prefetch_o,
  output logic      [1:0]                  prefetch_param_o,
  output logic      [tluh_pkg::TL_AW-1:0]  prefetch_addr_o
);

  // adapter <-> ALU
  logic [tluh_pkg::TL_DW-1:0] alu_op1, alu_op2, alu_result;
  logic                       alu_arith;
  logic [2:0]                 alu_fn;

  reg_bus_if #(.RegAw(RegAw)) reg_bus ();

  tluh_adapter_reg #(.RegAw(RegAw)) u_adapter (
    .clk_i, .rst_ni,
    .a_valid_i, .a_opcode_i, .a_param_i, .a_size_i, .a_source_i,
    .a_address_i, .a_mask_i, .a_data_i, .d_ready_i, .a_ready_o,
    .d_valid_o, .d_opcode_o, .d_size_o, .d_source_o, .d_data_o, .d_error_o,
    .prefetch_o, .prefetch_param_o, .prefetch_addr_o,
    .alu_op1_o    (alu_op1),
    .alu_op2_o    (alu_op2),
    .alu_arith_o  (alu_arith),
    .alu_fn_o     (alu_fn),
    .alu_result_i (alu_result),
    .reg_bus      (reg_bus.host)
  );

  reg_file #(.RegAw(RegAw), .NumRegs(NumRegs)) u_regs (
    .clk_i, .rst_ni,
    .reg_bus (reg_bus.device)
  );

  tluh_atomic_alu u_alu (
    .op1_i    (alu_op1),
    .op2_i    (alu_op2),
    .arith_i  (alu_arith),
    .fn_i     (alu_fn),
    .result_o (alu_result)
  );

endmodule

`default_nettype wire

// ==== verification/tluh_reg_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module tluh_reg_props (
  input wire logic                        clk_i,
  input wire logic                        rst_ni,
  input wire logic                        a_ready_i,
  input wire logic                        d_valid_i,
  input wire logic                        d_ready_i,
  input wire logic [2:0]                  d_opcode_i,
  input wire logic [tluh_pkg::TL_SZW-1:0] d_size_i,
  input wire logic [tluh_pkg::TL_IW-1:0]  d_source_i,
  input wire logic [tluh_pkg::TL_DW-1:0]  d_data_i,
  input wire logic                        d_error_i,
  input wire logic                        prefetch_i
);

  // stalled D beat keeps every field
  d_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_i && !d_ready_i |=> d_valid_i &&
      $stable({d_opcode_i, d_size_i, d_source_i, d_data_i, d_error_i}))
    else $error("D beat dropped or changed while d_ready_i was low");

  // D only rises after the last put beat
  a_d_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(a_ready_i && d_valid_i))
    else $error("A ready while D valid");

  hint_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    prefetch_i |=> !prefetch_i)
    else $error("prefetch held longer than one cycle");

endmodule

bind tluh_adapter_reg tluh_reg_props u_props (
  .clk_i, .rst_ni, .d_ready_i,
  .a_ready_i  (a_ready_o),
  .d_valid_i  (d_valid_o),
  .d_opcode_i (d_opcode_o),
  .d_size_i   (d_size_o),
  .d_source_i (d_source_o),
  .d_data_i   (d_data_o),
  .d_error_i  (d_error_o),
  .prefetch_i (prefetch_o)
);

`default_nettype wire

// ==== verification/tluh_reg_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module tluh_reg_tb;

  localparam int NUM_TESTS   = 31;
  localparam int NUM_REGS    = 12;
  localparam int WATCHDOG_NS = (NUM_TESTS * 40 + 5) * 100; // 40 cycles per entry

  typedef struct packed {
    tluh_pkg::tl_a_op_e op;
    logic [2:0]         param;
    logic [2:0]         size;  // log2 bytes where 2 is one beat
    logic [7:0]         addr;
    logic [3:0]         mask;
    logic [1:0]         stall; // max d_ready hold-off per beat
  } entry_t;

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////
  localparam entry_t TESTS [NUM_TESTS] = '{
    '{tluh_pkg::PutFullData,    3'd0,           3'd2, 8'h00, 4'hf, 2'd0},
    '{tluh_pkg::Get,            3'd0,           3'd2, 8'h00, 4'hf, 2'd1},
    '{tluh_pkg::PutPartialData, 3'd0,           3'd2, 8'h00, 4'h5, 2'd2},
    '{tluh_pkg::Get,            3'd0,           3'd2, 8'h00, 4'hf, 2'd0},
    '{tluh_pkg::PutPartialData, 3'd0,           3'd2, 8'h04, 4'ha, 2'd3},
    '{tluh_pkg::Get,            3'd0,           3'd2, 8'h04, 4'hf, 2'd1},
    '{tluh_pkg::PutFullData,    3'd0,           3'd4, 8'h00, 4'hf, 2'd1}, // bursts
    '{tluh_pkg::PutFullData,    3'd0,           3'd4, 8'h10, 4'hf, 2'd0},
    '{tluh_pkg::PutPartialData, 3'd0,           3'd3, 8'h20, 4'h6, 2'd2},
    '{tluh_pkg::PutFullData,    3'd0,           3'd3, 8'h3c, 4'hf, 2'd1}, // 15 wraps to 0
    '{tluh_pkg::Get,            3'd0,           3'd4, 8'h38, 4'hf, 2'd2},
    '{tluh_pkg::Get,            3'd0,           3'd3, 8'h1c, 4'hf, 2'd3},
    '{tluh_pkg::ArithmeticData, tluh_pkg::MIN,  3'd2, 8'h00, 4'hf, 2'd1}, // atomics
    '{tluh_pkg::ArithmeticData, tluh_pkg::MAX,  3'd2, 8'h04, 4'hf, 2'd0},
    '{tluh_pkg::ArithmeticData, tluh_pkg::MINU, 3'd2, 8'h08, 4'hf, 2'd2},
    '{tluh_pkg::ArithmeticData, tluh_pkg::MAXU, 3'd2, 8'h0c, 4'hf, 2'd3},
    '{tluh_pkg::ArithmeticData, tluh_pkg::ADD,  3'd2, 8'h10, 4'hf, 2'd1},
    '{tluh_pkg::LogicalData,    tluh_pkg::XOR,  3'd2, 8'h14, 4'hf, 2'd0},
    '{tluh_pkg::LogicalData,    tluh_pkg::OR,   3'd2, 8'h18, 4'hf, 2'd2},
    '{tluh_pkg::LogicalData,    tluh_pkg::AND,  3'd2, 8'h1c, 4'hf, 2'd1},
    '{tluh_pkg::LogicalData,    tluh_pkg::SWAP, 3'd2, 8'h20, 4'hf, 2'd3},
    '{tluh_pkg::Get,            3'd0,           3'd4, 8'h00, 4'hf, 2'd1},
    '{tluh_pkg::Get,            3'd0,           3'd4, 8'h10, 4'hf, 2'd2},
    '{tluh_pkg::Get,            3'd0,           3'd2, 8'h20, 4'hf, 2'd0},
    '{tluh_pkg::Get,            3'd0,           3'd2, 8'h30, 4'hf, 2'd1}, // error words
    '{tluh_pkg::PutFullData,    3'd0,           3'd2, 8'h34, 4'hf, 2'd2},
    '{tluh_pkg::Get,            3'd0,           3'd3, 8'h38, 4'hf, 2'd0},
    '{tluh_pkg::PutPartialData, 3'd0,           3'd2, 8'h3c, 4'h3, 2'd1},
    '{tluh_pkg::Get,            3'd0,           3'd4, 8'h20, 4'hf, 2'd3},
    '{tluh_pkg::Intent,         3'd1,           3'd2, 8'h24, 4'hf, 2'd0}, // hints
    '{tluh_pkg::Intent,         3'd2,           3'd2, 8'h78, 4'hf, 2'd2}  // lands on word 14
  };

  logic                             clk_i;
  logic                             rst_ni;
  logic                             a_valid_i;
  tluh_pkg::tl_a_op_e               a_opcode_i;
  logic [2:0]                       a_param_i;
  logic [tluh_pkg::TL_SZW-1:0]      a_size_i;
  logic [tluh_pkg::TL_IW-1:0]       a_source_i;
  logic [tluh_pkg::TL_AW-1:0]       a_address_i;
  logic [tluh_pkg::TL_DBW-1:0]      a_mask_i;
  logic [tluh_pkg::TL_DW-1:0]       a_data_i;
  logic                             d_ready_i;
  logic                             a_ready_o;
  logic                             d_valid_o;
  tluh_pkg::tl_d_op_e               d_opcode_o;
  logic [tluh_pkg::TL_SZW-1:0]      d_size_o;
  logic [tluh_pkg::TL_IW-1:0]       d_source_o;
  logic [tluh_pkg::TL_DW-1:0]       d_data_o;
  logic                             d_error_o;
  logic                             prefetch_o;
  logic [1:0]                       prefetch_param_o;
  logic [tluh_pkg::TL_AW-1:0]       prefetch_addr_o;

  logic [31:0] model [NUM_REGS]; // reference words
  logic [31:0] rng;
  logic [1:0]  pf_param;   // hint fields seen at the A handshake
  logic [31:0] pf_addr;
  int          pf_count;
  int          errors;
  int          checks;
  int          test_errs;

  tluh_reg_top #(.RegAw(6), .NumRegs(NUM_REGS)) dut0 (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (prefetch_o) pf_count++; // hint pulses taken at the edge
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the DUT stopped answering within %0d cycles", NUM_TESTS * 40);
    $display("test failed");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] mask);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) w[8*b +: 8] = data[8*b +: 8];
    end
    return w;
  endfunction

  // atomic result with a as the bus data and b as the old word
  function automatic logic [31:0] atomic_result(input logic arith, input logic [2:0] fn,
                                                input logic [31:0] a, input logic [31:0] b);
    if (arith) begin
      case (fn)
        tluh_pkg::MIN:  return ($signed(a) < $signed(b)) ? a : b;
        tluh_pkg::MAX:  return ($signed(a) > $signed(b)) ? a : b;
        tluh_pkg::MINU: return (a < b) ? a : b;
        tluh_pkg::MAXU: return (a > b) ? a : b;
        tluh_pkg::ADD:  return a + b;
        default:        return a;
      endcase
    end
    case (fn)
      tluh_pkg::XOR: return a ^ b;
      tluh_pkg::OR:  return a | b;
      tluh_pkg::AND: return a & b;
      default:       return a; // swap
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // channel drivers
  ////////////////////////////////////////////////////////////
  // one A beat that returns at the falling edge after the handshake
  task automatic send_beat(input entry_t e, input logic [3:0] src, input logic [31:0] data);
    logic taken;
    a_valid_i   = 1'b1;
    a_opcode_i  = e.op;
    a_param_i   = e.param;
    a_size_i    = e.size;
    a_source_i  = src;
    a_address_i = {24'h0, e.addr};
    a_mask_i    = e.mask;
    a_data_i    = data;
    taken       = 1'b0;
    while (!taken) begin
      #10; // comb outputs settled
      taken = a_ready_o;
      if (taken && prefetch_o) begin
        pf_param = prefetch_param_o;
        pf_addr  = prefetch_addr_o;
      end
      @(negedge clk_i);
    end
  endtask

  // one D beat after a random hold-off
  task automatic collect_beat(input int max_stall, input logic [2:0] exp_size,
                              input logic [3:0] exp_src, output tluh_pkg::tl_d_op_e op,
                              output logic [31:0] data, output logic err);
    int hold;
    rng  = xorshift(rng);
    hold = int'(rng % (max_stall + 1));
    while (!d_valid_o) begin
      @(negedge clk_i);
    end
    repeat (hold) begin
      check("a_ready_o", a_ready_o, 32'd0); // no A beat while D waits
      @(negedge clk_i);
      check("d_valid_o", d_valid_o, 32'd1);
    end
    check("a_ready_o", a_ready_o, 32'd0);
    check("d_size_o", d_size_o, exp_size);
    check("d_source_o", d_source_o, exp_src);
    op        = d_opcode_o;
    data      = d_data_o;
    err       = d_error_o;
    d_ready_i = 1'b1;
    @(negedge clk_i);
    d_ready_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // one table entry against the model
  ////////////////////////////////////////////////////////////
  task automatic run_entry(input int n, input entry_t e);
    int                 beats;
    int                 idx;
    int                 pf_before;
    logic               err_acc;
    logic [31:0]        data;
    logic [31:0]        old;
    logic [31:0]        rdat;
    logic               rerr;
    logic [3:0]         src;
    tluh_pkg::tl_d_op_e op;
    src       = n[3:0];
    beats     = (e.size > 3'd2) ? (1 << (e.size - 3'd2)) : 1;
    idx       = int'(e.addr[5:2]);
    pf_before = pf_count;
    err_acc   = 1'b0;
    case (e.op)
      tluh_pkg::Get: begin
        send_beat(e, src, 32'h0);
        a_valid_i = 1'b0;
        for (int b = 0; b < beats; b++) begin
          collect_beat(e.stall, e.size, src, op, rdat, rerr);
          check("d_opcode_o", op, tluh_pkg::AccessAckData);
          check("d_data_o", rdat, (idx < NUM_REGS) ? model[idx] : 32'h0); // holes read zero
          check("d_error_o", rerr, idx >= NUM_REGS);
          idx = (idx + 1) % 16; // wraps inside the 64 byte space
        end
      end
      tluh_pkg::PutFullData, tluh_pkg::PutPartialData: begin
        for (int b = 0; b < beats; b++) begin
          rng  = xorshift(rng);
          data = rng;
          send_beat(e, src, data);
          if (idx < NUM_REGS) model[idx] = merge_bytes(model[idx], data, e.mask);
          else err_acc = 1'b1; // dropped beat
          idx = (idx + 1) % 16;
        end
        a_valid_i = 1'b0;
        collect_beat(e.stall, e.size, src, op, rdat, rerr);
        check("d_opcode_o", op, tluh_pkg::AccessAck);
        check("d_error_o", rerr, err_acc);
      end
      tluh_pkg::ArithmeticData, tluh_pkg::LogicalData: begin
        rng  = xorshift(rng);
        data = rng;
        old  = (idx < NUM_REGS) ? model[idx] : 32'h0;
        send_beat(e, src, data);
        a_valid_i = 1'b0;
        collect_beat(e.stall, e.size, src, op, rdat, rerr);
        check("d_opcode_o", op, tluh_pkg::AccessAckData);
        check("d_data_o", rdat, old); // old word comes back
        check("d_error_o", rerr, idx >= NUM_REGS);
        if (idx < NUM_REGS) begin
          model[idx] = atomic_result(e.op == tluh_pkg::ArithmeticData, e.param, data, old);
        end
      end
      default: begin // intent
        send_beat(e, src, 32'h0);
        a_valid_i = 1'b0;
        check("prefetch_param_o", pf_param, e.param[1:0]);
        check("prefetch_addr_o", pf_addr, {24'h0, e.addr});
        collect_beat(e.stall, e.size, src, op, rdat, rerr);
        check("d_opcode_o", op, tluh_pkg::HintAck);
        check("d_error_o", rerr, 32'd0);
      end
    endcase
    check("prefetch_o pulses", pf_count - pf_before, e.op == tluh_pkg::Intent);
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = tluh_pkg::Get;
    a_param_i   = '0;
    a_size_i    = '0;
    a_source_i  = '0;
    a_address_i = '0;
    a_mask_i    = '0;
    a_data_i    = '0;
    d_ready_i   = 1'b0;
    rng         = 32'hf089_68d4;
    pf_param    = '0;
    pf_addr     = '0;
    pf_count    = 0;
    errors      = 0;
    checks      = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model[i] = '0; // array clears on reset
    end
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    for (int n = 0; n < NUM_TESTS; n++) begin
      test_errs = 0;
      run_entry(n, TESTS[n]);
      $display("entry %0d %s: %s", n, TESTS[n].op.name(), (test_errs == 0) ? "ok" : "mismatch");
    end
    $display("%0d entries, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
src/tluh_pkg.sv
src/reg_bus_if.sv
src/tluh_atomic_alu.sv
src/tluh_adapter_reg.sv
src/reg_file.sv
src/tluh_reg_top.sv
verification/tluh_reg_props.sv
verification/tluh_reg_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the register adapter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tluh_reg_tb -f tb.f -o Vtluh_reg_tb

./obj_dir/Vtluh_reg_tb | tee sim.log

# the run counts as passed only if the testbench said so
grep -qx "test passed" sim.log
echo "simulation passed"
